// ==== files.f ====
+incdir+dv
src/rv_pkg.sv
src/alu_decoder.sv
src/alu.sv
src/reg_file.sv
src/instr_decode.sv
src/exec_ctrl.sv
src/rv_exec_core.sv
dv/tb_rv_exec_core.sv

// ==== dv/rv_ref_model.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// major opcodes as the ISA defines them
localparam logic [6:0] OP_R      = 7'b0110011;
localparam logic [6:0] OP_I      = 7'b0010011;
localparam logic [6:0] OP_LOAD   = 7'b0000011;
localparam logic [6:0] OP_STORE  = 7'b0100011;
localparam logic [6:0] OP_BRANCH = 7'b1100011;
localparam logic [6:0] OP_JAL    = 7'b1101111;
localparam logic [6:0] OP_JALR   = 7'b1100111;
localparam logic [6:0] OP_LUI    = 7'b0110111;
localparam logic [6:0] OP_AUIPC  = 7'b0010111;
localparam logic [6:0] OP_FENCE  = 7'b0001111;
localparam logic [6:0] OP_SYSTEM = 7'b1110011;

logic [31:0] ref_regs [32];
logic [31:0] ref_pc;
int          ref_taken;
int          ref_not_taken;

task automatic ref_reset(input logic [31:0] start_pc);
  for (int i = 0; i < 32; i++) begin
    ref_regs[i] = 32'd0;
  end
  ref_pc        = start_pc;
  ref_taken     = 0;
  ref_not_taken = 0;
endtask

function automatic logic [31:0] ref_read(input logic [4:0] idx);
  return (idx == 5'd0) ? 32'd0 : ref_regs[idx];
endfunction

// alt picks sub for funct3 000 and the arithmetic shift for 101
function automatic logic [31:0] ref_calc(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
  logic signed [31:0] sa;
  logic [31:0]        res;
  sa = a;
  case (f3)
    3'b000: begin
      if (alt) res = a - b;
      else res = a + b;
    end
    3'b001: res = a << b[4:0];
    3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011: res = (a < b) ? 32'd1 : 32'd0;
    3'b100: res = a ^ b;
    3'b101: begin
      if (alt) res = sa >>> b[4:0]; // sign fill
      else res = a >> b[4:0];
    end
    3'b110: res = a | b;
    default: res = a & b;
  endcase
  return res;
endfunction

function automatic logic ref_branch(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
  case (f3)
    3'b000: return a == b;
    3'b001: return a != b;
    3'b100: return $signed(a) < $signed(b);
    3'b101: return $signed(a) >= $signed(b);
    3'b110: return a < b;
    default: return a >= b;
  endcase
endfunction

// runs one instruction on the model state, returns the expected writeback
task automatic ref_execute(input logic [31:0] word, output logic wr,
                           output logic [4:0] wrd, output logic [31:0] wdata);
  logic [4:0]  rd;
  logic [2:0]  f3;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] imm_u;
  logic [31:0] nxt;
  logic [31:0] res;
  rd    = word[11:7];
  f3    = word[14:12];
  a     = ref_read(word[19:15]);
  b     = ref_read(word[24:20]);
  imm_i = {{20{word[31]}}, word[31:20]};
  imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
  imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
  imm_u = {word[31:12], 12'd0};
  nxt   = ref_pc + 32'd4;
  res   = 32'd0;
  wr    = 1'b0;
  case (word[6:0])
    OP_R: begin
      wr  = 1'b1;
      res = ref_calc(f3, word[30], a, b);
    end
    OP_I: begin
      wr  = 1'b1;
      res = ref_calc(f3, (f3 == 3'b101) && word[30], a, imm_i); // no subi
    end
    OP_LUI: begin
      wr  = 1'b1;
      res = imm_u;
    end
    OP_AUIPC: begin
      wr  = 1'b1;
      res = ref_pc + imm_u;
    end
    OP_JAL: begin
      wr  = 1'b1;
      res = ref_pc + 32'd4;
      nxt = ref_pc + imm_j;
    end
    OP_JALR: begin
      wr  = 1'b1;
      res = ref_pc + 32'd4;
      nxt = (a + imm_i) & ~32'd1;
    end
    OP_BRANCH: begin
      if (ref_branch(f3, a, b)) begin
        nxt = ref_pc + imm_b;
        ref_taken++;
      end else begin
        ref_not_taken++;
      end
    end
    default: ; // loads, stores, fence, system and unknown retire as no-ops
  endcase
  wr    = wr && (rd != 5'd0);
  wrd   = rd;
  wdata = res;
  if (wr) ref_regs[rd] = res;
  ref_pc = nxt;
endtask

`endif

// ==== dv/tb_rv_exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec_core;

  localparam logic [31:0] RESET_PC   = 32'h0000_1000;
  localparam int          NUM_INSTR  = 400;
  localparam int          SEED       = 62474;
  localparam int          ACK_WAIT   = 10;
  localparam int          MAX_CYCLES = 5 + NUM_INSTR * 8 + 100;

  logic        clk;
  logic        rst_n;
  logic        instr_req;
  logic [31:0] instr;
  logic        instr_ack;
  logic        wb_en;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic [31:0] pc;

  int          errors;
  int          cycles;
  int          wb_pulses;
  logic [4:0]  wb_rd_seen;
  logic [31:0] wb_data_seen;

  `include "rv_ref_model.svh"

  rv_exec_core #(
    .NUM_REGS (32),
    .RESET_PC (RESET_PC)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .instr_req (instr_req),
    .instr     (instr),
    .instr_ack (instr_ack),
    .wb_en     (wb_en),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .pc        (pc)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic log_fail(input string msg);
    errors++;
    $display("FAIL at %0t: %s", $time, msg);
  endtask

  // outputs are sampled on the falling edge, away from the drive edge
  task automatic watch_cycle();
    @(negedge clk);
    if (wb_en) begin
      wb_pulses++;
      wb_rd_seen   = wb_rd;
      wb_data_seen = wb_data;
    end
  endtask

  function automatic logic [31:0] gen_instr();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [6:0]  nop_op;
    logic [31:0] rnd;
    rd  = 5'($urandom);
    rs1 = 5'($urandom);
    rs2 = 5'($urandom);
    f3  = 3'($urandom);
    rnd = $urandom;
    f7  = ((f3 == 3'b000 || f3 == 3'b101) && rnd[0]) ? 7'h20 : 7'h00;
    case ($urandom_range(0, 4))
      0: nop_op = OP_LOAD;
      1: nop_op = OP_STORE;
      2: nop_op = OP_FENCE;
      3: nop_op = OP_SYSTEM;
      default: nop_op = 7'b1111111;
    endcase
    case ($urandom_range(0, 11))
      0, 1, 2: return {f7, rs2, rs1, f3, rd, OP_R};
      3, 4, 5: begin
        if (f3 == 3'b001 || f3 == 3'b101) begin
          return {f7, rnd[24:20], rs1, f3, rd, OP_I}; // shamt in rs2 slot
        end
        return {rnd[31:20], rs1, f3, rd, OP_I};
      end
      6: return {rnd[31:12], rd, OP_LUI};
      7: return {rnd[31:12], rd, OP_AUIPC};
      8: return {rnd[31:25], rs2, rs1, f3[2] | f3[1], f3[1:0], rnd[11:7], OP_BRANCH};
      9: return {rnd[31:12], rd, OP_JAL};
      10: return {rnd[31:20], rs1, 3'b000, rd, OP_JALR};
      default: return {rnd[31:7], nop_op};
    endcase
  endfunction

  task automatic run_instr(input logic [31:0] word);
    logic        exp_wr;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    int          waited;
    int          hold;
    ref_execute(word, exp_wr, exp_rd, exp_data);
    hold      = $urandom_range(0, 3);
    wb_pulses = 0;
    @(posedge clk);
    instr_req <= 1'b1;
    instr     <= word;
    watch_cycle(); // req not yet sampled
    waited = 0;
    do begin
      watch_cycle();
      waited++;
    end while (!instr_ack && waited < ACK_WAIT);
    if (!instr_ack) begin
      errors++;
      $display("instr_ack never rose for instruction %h", word);
    end else if (waited != 2) begin
      log_fail($sformatf("ack %0d cycles after req sampled, expected 2", waited));
    end
    if (pc !== ref_pc) log_fail($sformatf("instr %h: pc %h, expected %h", word, pc, ref_pc));
    repeat (hold) begin
      watch_cycle();
      if (!instr_ack) log_fail("instr_ack fell while instr_req was held");
    end
    @(posedge clk);
    instr_req <= 1'b0;
    watch_cycle();
    if (!instr_ack) log_fail("instr_ack fell before req low was sampled");
    watch_cycle();
    if (instr_ack) log_fail("instr_ack still high one cycle after req dropped");
    if (exp_wr) begin
      if (wb_pulses != 1) begin
        log_fail($sformatf("instr %h: %0d wb_en pulses, expected 1", word, wb_pulses));
      end else if (wb_rd_seen !== exp_rd || wb_data_seen !== exp_data) begin
        log_fail($sformatf("instr %h: wb x%0d=%h, expected x%0d=%h", word,
                           wb_rd_seen, wb_data_seen, exp_rd, exp_data));
      end
    end else if (wb_pulses != 0) begin
      log_fail($sformatf("instr %h: wb_en pulsed with no writeback expected", word));
    end
  endtask

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stalled: %0d cycles passed before all instructions retired", cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    errors    = 0;
    wb_pulses = 0;
    instr_req = 1'b0;
    instr     = 32'd0;
    rst_n     = 1'b0;
    void'($urandom(SEED));
    ref_reset(RESET_PC);
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (instr_ack !== 1'b0 || wb_en !== 1'b0) log_fail("instr_ack or wb_en high after reset");
    if (pc !== RESET_PC) log_fail($sformatf("pc %h after reset, expected %h", pc, RESET_PC));
    for (int n = 0; n < NUM_INSTR; n++) begin
      run_instr(gen_instr());
    end
    if (ref_taken == 0 || ref_not_taken == 0) begin
      errors++;
      $display("branch mix incomplete: %0d taken, %0d not taken", ref_taken, ref_not_taken);
    end
    $display("errors: %0d over %0d instructions", errors, NUM_INSTR);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/rv_exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exec_core
  import rv_pkg::*;
#(
  parameter int          NUM_REGS = 32,
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_req,
  input  logic [31:0] instr,
  output logic        instr_ack,
  output logic        wb_en,
  output logic [4:0]  wb_rd,
  output logic [31:0] wb_data,
  output logic [31:0] pc
);

  instr_u      ir;
  opcode_t     opcode;
  alu_ctrl_t   alu_ctrl;
  imm_t        imm_ext;
  logic [2:0]  funct3;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic        reg_write;
  logic        alu_src_imm;
  logic        alu_a_pc;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] alu_a;
  logic [31:0] alu_b;
  logic [31:0] alu_result;

  exec_ctrl #(.RESET_PC(RESET_PC)) u_exec_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_req   (instr_req),
    .instr       (instr),
    .instr_ack   (instr_ack),
    .ir          (ir),
    .opcode      (opcode),
    .funct3      (funct3),
    .rd          (rd),
    .imm_ext     (imm_ext),
    .reg_write   (reg_write),
    .alu_a_pc    (alu_a_pc),
    .alu_src_imm (alu_src_imm),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .alu_result  (alu_result),
    .alu_a       (alu_a),
    .alu_b       (alu_b),
    .wb_en       (wb_en),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .pc          (pc)
  );

  instr_decode u_instr_decode (
    .ir          (ir),
    .opcode      (opcode),
    .alu_ctrl    (alu_ctrl),
    .imm_ext     (imm_ext),
    .funct3      (funct3),
    .rd          (rd),
    .rs1         (rs1),
    .rs2         (rs2),
    .reg_write   (reg_write),
    .alu_src_imm (alu_src_imm),
    .alu_a_pc    (alu_a_pc)
  );

  reg_file #(.NUM_REGS(NUM_REGS)) u_reg_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .wr_addr  (wb_rd),
    .wr_en    (wb_en),
    .wr_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu u_alu (
    .a        (alu_a),
    .b        (alu_b),
    .alu_ctrl (alu_ctrl),
    .result   (alu_result)
  );

endmodule

`default_nettype wire

// ==== src/exec_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl
  import rv_pkg::*;
#(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_req,
  input  logic [31:0] instr,
  output logic        instr_ack,
  output instr_u      ir,
  input  opcode_t     opcode,
  input  logic [2:0]  funct3,
  input  logic [4:0]  rd,
  input  imm_t        imm_ext,
  input  logic        reg_write,
  input  logic        alu_a_pc,
  input  logic        alu_src_imm,
  input  logic [31:0] rs1_data,
  input  logic [31:0] rs2_data,
  input  logic [31:0] alu_result,
  output logic [31:0] alu_a,
  output logic [31:0] alu_b,
  output logic        wb_en,
  output logic [4:0]  wb_rd,
  output logic [31:0] wb_data,
  output logic [31:0] pc
);

  localparam logic [1:0] IDLE = 2'd0;
  localparam logic [1:0] EXEC = 2'd1;
  localparam logic [1:0] ACK  = 2'd2;

  logic [1:0]  state;
  logic [31:0] pc_plus4;
  logic [31:0] pc_target;
  logic [31:0] next_pc;
  logic        cmp;
  logic        taken;
  logic        is_jump;

  assign alu_a = alu_a_pc ? pc : rs1_data;
  assign alu_b = alu_src_imm ? imm_ext : rs2_data;

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm_ext;

  // eq/ne look at the difference, the rest at the slt bit
  assign cmp   = funct3[2] ? alu_result[0] : (alu_result == 32'd0);
  assign taken = funct3[0] ? !cmp : cmp;

  assign is_jump = (opcode == JTYPE) || (opcode == ITYPE_JALR);

  always_comb begin
    case (opcode)
      BTYPE:      next_pc = taken ? pc_target : pc_plus4;
      JTYPE:      next_pc = pc_target;
      ITYPE_JALR: next_pc = {alu_result[31:1], 1'b0};
      default:    next_pc = pc_plus4;
    endcase
  end

  // retirement happens during the single EXEC cycle
  assign wb_en   = (state == EXEC) && reg_write;
  assign wb_rd   = rd;
  assign wb_data = is_jump ? pc_plus4 : alu_result; // link value for jumps

  always_ff @(posedge clk) begin
    if (state == IDLE && instr_req) begin
      ir <= instr;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      instr_ack <= 1'b0;
      pc        <= RESET_PC;
    end else begin
      case (state)
        IDLE: if (instr_req) state <= EXEC;
        EXEC: begin
          pc        <= next_pc;
          instr_ack <= 1'b1;
          state     <= ACK;
        end
        ACK: begin
          if (!instr_req) begin // requester saw ack, close the handshake
            instr_ack <= 1'b0;
            state     <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  a_ack_held: assert property (@(posedge clk) disable iff (!rst_n)
    instr_ack && instr_req |=> instr_ack);

  a_wb_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_en |=> !wb_en);

endmodule

`default_nettype wire

// ==== src/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode
  import rv_pkg::*;
(
  input  instr_u     ir,
  output opcode_t    opcode,
  output alu_ctrl_t  alu_ctrl,
  output imm_t       imm_ext,
  output logic [2:0] funct3,
  output logic [4:0] rd,
  output logic [4:0] rs1,
  output logic [4:0] rs2,
  output logic       reg_write,
  output logic       alu_src_imm,
  output logic       alu_a_pc
);

  alu_op_t    alu_op;
  logic [6:0] funct7;
  logic       is_imm;
  logic       writes_rd;

  assign opcode = opcode_t'(ir.r_fmt.opcode);

  // register fields, zero where the format has none
  always_comb begin
    rd     = 5'd0;
    rs1    = 5'd0;
    rs2    = 5'd0;
    funct3 = 3'd0;
    funct7 = 7'd0;
    case (opcode)
      RTYPE: begin
        rd     = ir.r_fmt.rd;
        rs1    = ir.r_fmt.rs1;
        rs2    = ir.r_fmt.rs2;
        funct3 = ir.r_fmt.funct3;
        funct7 = ir.r_fmt.funct7;
      end
      ITYPE_ALU: begin
        rd     = ir.i_fmt.rd;
        rs1    = ir.i_fmt.rs1;
        funct3 = ir.i_fmt.funct3;
        funct7 = ir.r_fmt.funct7; // shift immediates carry the sra bit here
      end
      ITYPE_LOAD, ITYPE_JALR: begin
        rd     = ir.i_fmt.rd;
        rs1    = ir.i_fmt.rs1;
        funct3 = ir.i_fmt.funct3;
      end
      STYPE: begin
        rs1    = ir.s_fmt.rs1;
        rs2    = ir.s_fmt.rs2;
        funct3 = ir.s_fmt.funct3;
      end
      BTYPE: begin
        rs1    = ir.b_fmt.rs1;
        rs2    = ir.b_fmt.rs2;
        funct3 = ir.b_fmt.funct3;
      end
      JTYPE: rd = ir.j_fmt.rd;
      UTYPE_LUI, UTYPE_AUIPC: rd = ir.u_fmt.rd; // lui leaves rs1 at x0
      default: ;
    endcase
  end

  always_comb begin
    case (opcode)
      ITYPE_ALU, ITYPE_LOAD, ITYPE_JALR:
        imm_ext = {{20{ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
      STYPE:
        imm_ext = {{20{ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_hi, ir.s_fmt.imm_lo};
      BTYPE:
        imm_ext = {{20{ir.b_fmt.imm12}}, ir.b_fmt.imm11, ir.b_fmt.imm10_5,
                   ir.b_fmt.imm4_1, 1'b0};
      JTYPE:
        imm_ext = {{12{ir.j_fmt.imm20}}, ir.j_fmt.imm19_12, ir.j_fmt.imm11,
                   ir.j_fmt.imm10_1, 1'b0};
      UTYPE_LUI, UTYPE_AUIPC:
        imm_ext = {ir.u_fmt.imm, 12'd0};
      default:
        imm_ext = 32'd0;
    endcase
  end

  always_comb begin
    alu_op      = ALU_OP_UNSET;
    is_imm      = 1'b0;
    alu_src_imm = 1'b0;
    alu_a_pc    = 1'b0;
    writes_rd   = 1'b0;
    case (opcode)
      RTYPE: begin
        alu_op    = ALU_OP_REG;
        writes_rd = 1'b1;
      end
      ITYPE_ALU: begin
        alu_op      = ALU_OP_REG;
        is_imm      = 1'b1;
        alu_src_imm = 1'b1;
        writes_rd   = 1'b1;
      end
      ITYPE_LOAD, STYPE: begin
        alu_op      = ALU_OP_ADD; // address only, retires as a no-op
        alu_src_imm = 1'b1;
      end
      ITYPE_JALR, UTYPE_LUI: begin
        alu_op      = ALU_OP_ADD; // rs1 + imm, x0 + imm for lui
        alu_src_imm = 1'b1;
        writes_rd   = 1'b1;
      end
      UTYPE_AUIPC: begin
        alu_op      = ALU_OP_ADD;
        alu_src_imm = 1'b1;
        alu_a_pc    = 1'b1;
        writes_rd   = 1'b1;
      end
      BTYPE: alu_op = ALU_OP_BRANCH;
      JTYPE: writes_rd = 1'b1;
      default: ;
    endcase
  end

  assign reg_write = writes_rd && (rd != 5'd0);

  alu_decoder u_alu_decoder (
    .alu_op   (alu_op),
    .funct3   (funct3),
    .funct7   (funct7),
    .is_imm   (is_imm),
    .alu_ctrl (alu_ctrl)
  );

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
  parameter int NUM_REGS = 32
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  wr_addr,
  input  logic        wr_en,
  input  logic [31:0] wr_data,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data
);

  localparam int AW = $clog2(NUM_REGS);

  logic [31:0]   regs [NUM_REGS];
  logic [AW-1:0] ra1;
  logic [AW-1:0] ra2;
  logic [AW-1:0] wa;

  // upper address bits are dropped for the rv32e size
  assign ra1 = rs1[AW-1:0];
  assign ra2 = rs2[AW-1:0];
  assign wa  = wr_addr[AW-1:0];

  assign rs1_data = (ra1 == '0) ? 32'd0 : regs[ra1];
  assign rs2_data = (ra2 == '0) ? 32'd0 : regs[ra2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (wr_en && wa != '0) begin
      regs[wa] <= wr_data;
    end
  end

  // decoder must already have dropped writes to x0
  a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> wr_addr != 5'd0);

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
  import rv_pkg::*;
(
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  alu_ctrl_t   alu_ctrl,
  output logic [31:0] result
);

  logic [4:0] shamt;

  assign shamt = b[4:0]; // only the low five bits count

  always_comb begin
    case (alu_ctrl)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
      ALU_SLTU: result = {31'd0, a < b};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/alu_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_decoder
  import rv_pkg::*;
(
  input  alu_op_t    alu_op,
  input  logic [2:0] funct3,
  input  logic [6:0] funct7,
  input  logic       is_imm,   // I-type alu, no SUB form
  output alu_ctrl_t  alu_ctrl
);

  always_comb begin
    alu_ctrl = ALU_ADD;
    case (alu_op)
      ALU_OP_ADD: alu_ctrl = ALU_ADD;
      ALU_OP_REG: begin
        case (funct3)
          3'b000: alu_ctrl = (!is_imm && funct7[5]) ? ALU_SUB : ALU_ADD;
          3'b001: alu_ctrl = ALU_SLL;
          3'b010: alu_ctrl = ALU_SLT;
          3'b011: alu_ctrl = ALU_SLTU;
          3'b100: alu_ctrl = ALU_XOR;
          3'b101: alu_ctrl = funct7[5] ? ALU_SRA : ALU_SRL; // srai keeps bit 30 too
          3'b110: alu_ctrl = ALU_OR;
          default: alu_ctrl = ALU_AND;
        endcase
      end
      ALU_OP_BRANCH: begin
        // beq/bne compare by subtracting, the others by set-less-than
        case (funct3[2:1])
          2'b10:   alu_ctrl = ALU_SLT;
          2'b11:   alu_ctrl = ALU_SLTU;
          default: alu_ctrl = ALU_SUB;
        endcase
      end
      default: alu_ctrl = ALU_ADD;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // major opcodes, bits 6:0 of every instruction
  typedef enum logic [6:0] {
    RTYPE       = 7'b0110011,
    ITYPE_ALU   = 7'b0010011,
    ITYPE_LOAD  = 7'b0000011,
    ITYPE_JALR  = 7'b1100111,
    STYPE       = 7'b0100011,
    BTYPE       = 7'b1100011,
    JTYPE       = 7'b1101111,
    UTYPE_LUI   = 7'b0110111,
    UTYPE_AUIPC = 7'b0010111,
    FENCE       = 7'b0001111
  } opcode_t;

  // operation class handed from the main decoder to the alu decoder
  typedef enum logic [1:0] {
    ALU_OP_ADD    = 2'b00,
    ALU_OP_REG    = 2'b01, // look at funct3/funct7
    ALU_OP_BRANCH = 2'b10,
    ALU_OP_UNSET  = 2'b11
  } alu_op_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_ctrl_t;

  typedef logic [31:0] imm_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // branch offset bits are scattered across the word
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

endpackage

`default_nettype wire
